/* common/jesd_tpl_pkg.sv */
`default_nettype none

package jesd_tpl_pkg;

  // **************************************************
  // link configuration
  // **************************************************

  // two lanes carrying two converters, 14-bit samples
  localparam int num_lanes = 2;
  localparam int num_channels = 2;
  localparam int channel_width = 14;

  // samples across all channels per clock, two per channel
  localparam int samples_per_frame = 4;

  // each sample rides in a 16-bit octet pair
  // the low bits of the second octet are padding
  localparam int adc_sample_width = 16;
  localparam int tail_bits = adc_sample_width - channel_width;

  // output buffer depth in frames
  localparam int fifo_depth = 8;

  // **************************************************
  // vector types
  // **************************************************

  // all lanes' octets, lane 0 in bits 31:0
  typedef logic [num_lanes*32-1:0] link_word_t;

  // one-hot octet position of start of frame
  typedef logic [3:0] sof_t;

  // packed raw samples, sample 0 in the low bits
  typedef logic [samples_per_frame*channel_width-1:0] frame_t;

  // packed 16-bit samples as delivered to the user
  typedef logic [samples_per_frame*adc_sample_width-1:0] adc_frame_t;

  // occupancy, one extra bit so full can be told from empty
  typedef logic [$clog2(fifo_depth):0] fifo_count_t;

endpackage

`default_nettype wire

/* deframer/tpl_adc_deframer.sv */
`timescale 1ns/1ps
`default_nettype none

module tpl_adc_deframer
  import jesd_tpl_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  wire link_word_t aligned_data,
  input  wire        aligned_valid,
  output frame_t     frame_data,
  output logic       frame_valid
);

  // unregistered sample frame
  frame_t frame_c;

  // **************************************************
  // octet to sample mapping
  // **************************************************

  // sample k lives in octets 2k and 2k+1 of the aligned word
  // channel ch owns a contiguous run of samples
  for (genvar ch = 0; ch < num_channels; ch++) begin : g_channel
    for (genvar j = 0; j < samples_per_frame / num_channels; j++) begin : g_sample
      // big-endian pair, first octet gives the high bits
      // second octet loses its tail bits at the bottom
      assign frame_c[(ch*(samples_per_frame/num_channels)+j)*channel_width +: channel_width] = {
        aligned_data[(ch*(samples_per_frame/num_channels)+j)*16 +: 8],
        aligned_data[(ch*(samples_per_frame/num_channels)+j)*16+8+tail_bits +: 8-tail_bits]
      };
    end
  end

  // **************************************************
  // output register
  // **************************************************

  // payload is captured every cycle, the valid qualifies it
  always_ff @(posedge clk) begin
    frame_data <= frame_c;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= aligned_valid;
    end
  end

endmodule

`default_nettype wire

/* lane_align/jesd_rx_lane_align.sv */
`timescale 1ns/1ps
`default_nettype none

module jesd_rx_lane_align
  import jesd_tpl_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  wire sof_t  link_sof,
  input  wire link_word_t link_data,
  output link_word_t aligned_data,
  output logic       aligned_valid
);

  // octet position decoded from the one-hot marker
  logic [1:0] sof_pos;
  // position held once the link has shown a frame start
  logic [1:0] offset_q;
  logic       locked;
  // offset applied this cycle
  logic [1:0] offset_sel;

  // **************************************************
  // frame start detection
  // **************************************************

  // marker is one-hot, so the last set bit is the only one
  always_comb begin
    sof_pos = 2'd0;
    for (int p = 0; p < 4; p++) begin
      if (link_sof[p]) begin
        sof_pos = 2'(p);
      end
    end
  end

  // on the latching cycle the fresh position is used directly
  assign offset_sel = locked ? offset_q : sof_pos;

  always_ff @(posedge clk) begin
    if (rst) begin
      locked <= 1'b0;
      offset_q <= 2'd0;
      aligned_valid <= 1'b0;
    end else begin
      // first marker wins, later markers are ignored
      if (!locked && (link_sof != '0)) begin
        locked <= 1'b1;
        offset_q <= sof_pos;
      end
      // one aligned word per clock from the latching cycle on
      aligned_valid <= locked | (|link_sof);
    end
  end

  // **************************************************
  // per lane octet shifter
  // **************************************************

  for (genvar n = 0; n < num_lanes; n++) begin : g_lane
    logic [31:0] prev_word;
    logic [63:0] word_pair;
    logic [31:0] word_q;

    // current word on top, last word below
    assign word_pair = {link_data[n*32 +: 32], prev_word};

    always_ff @(posedge clk) begin
      prev_word <= link_data[n*32 +: 32];
      // four octets starting at the frame start position
      word_q <= word_pair[offset_sel*8 +: 32];
    end

    assign aligned_data[n*32 +: 32] = word_q;
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds and runs the JESD204 transport layer testbench with Verilator
# the exit status is the simulator's, nonzero when the testbench fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_jesd_tpl_adc \
  -f sources.f \
  -Mdir obj_dir \
  -o sim_tb_jesd_tpl_adc
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_tb_jesd_tpl_adc
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit "$status"
fi

echo "simulation exited cleanly"
exit 0

/* sources.f */
common/jesd_tpl_pkg.sv
lane_align/jesd_rx_lane_align.sv
deframer/tpl_adc_deframer.sv
src/adc_sample_fifo.sv
src/adc_data_format.sv
src/jesd_tpl_adc.sv
tb/jesd_tpl_adc_asserts.sv
tb/tb_jesd_tpl_adc.sv

/* src/adc_data_format.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_data_format
  import jesd_tpl_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         empty,
  input  wire         hold,
  input  wire         offset_binary,
  output logic        rd,
  input  wire frame_t rd_data,
  output adc_frame_t  adc_data,
  output logic        adc_valid
);

  // **************************************************
  // read request
  // **************************************************

  // pull a frame whenever one is stored and the user is not holding
  assign rd = ~empty & ~hold;

  // the fifo's output register holds the frame one cycle after rd,
  // so the valid is that same read delayed once
  always_ff @(posedge clk) begin
    if (rst) begin
      adc_valid <= 1'b0;
    end else begin
      adc_valid <= rd;
    end
  end

  // **************************************************
  // sample formatting
  // **************************************************

  // works on the registered fifo output, lines up with adc_valid
  for (genvar k = 0; k < samples_per_frame; k++) begin : g_sample
    logic [channel_width-1:0] raw;
    logic [channel_width-1:0] twos;

    assign raw = rd_data[k*channel_width +: channel_width];

    // offset binary to two's complement is an msb flip
    assign twos = {raw[channel_width-1] ^ offset_binary, raw[channel_width-2:0]};

    // replicate the sign into the upper bits
    assign adc_data[k*adc_sample_width +: adc_sample_width] = {
      {(adc_sample_width-channel_width){twos[channel_width-1]}},
      twos
    };
  end

endmodule

`default_nettype wire

/* src/adc_sample_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_sample_fifo
  import jesd_tpl_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         wr,
  input  wire frame_t wr_data,
  input  wire         rd,
  output frame_t      rd_data,
  output logic        empty,
  output logic        overflow
);

  // storage, one frame per entry
  frame_t mem [fifo_depth];

  // pointers wrap naturally at the power of two depth
  logic [$clog2(fifo_depth)-1:0] wr_ptr;
  logic [$clog2(fifo_depth)-1:0] rd_ptr;
  fifo_count_t count;

  logic full;
  // write that actually lands in memory
  logic wr_en;

  // **************************************************
  // status
  // **************************************************

  assign full = (count == fifo_count_t'(fifo_depth));
  assign empty = (count == '0);

  // a write while full is dropped on the floor
  assign wr_en = wr & ~full;

  // **************************************************
  // data path
  // **************************************************

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // read data shows up on the cycle after rd
  // the reader is trusted to check empty first
  always_ff @(posedge clk) begin
    if (rd) begin
      rd_data <= mem[rd_ptr];
    end
  end

  // **************************************************
  // pointers, count and overflow
  // **************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      overflow <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous write and read leaves the count alone
      case ({wr_en, rd})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      // sticky until reset
      if (wr && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/jesd_tpl_adc.sv */
`timescale 1ns/1ps
`default_nettype none

module jesd_tpl_adc
  import jesd_tpl_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire sof_t   link_sof,
  input  wire link_word_t link_data,
  input  wire         adc_hold,
  input  wire         offset_binary,
  output adc_frame_t  adc_data,
  output logic        adc_valid,
  output logic        adc_overflow
);

  // aligner to deframer
  link_word_t aligned_data;
  logic       aligned_valid;

  // deframer to buffer
  frame_t     frame_data;
  logic       frame_valid;

  // buffer to formatter
  frame_t     rd_data;
  logic       fifo_rd;
  logic       empty;

  // **************************************************
  // receive chain
  // **************************************************

  jesd_rx_lane_align jesd_rx_lane_align_i (
    .clk           (clk),
    .rst           (rst),
    .link_sof      (link_sof),
    .link_data     (link_data),
    .aligned_data  (aligned_data),
    .aligned_valid (aligned_valid)
  );

  tpl_adc_deframer tpl_adc_deframer_i (
    .clk           (clk),
    .rst           (rst),
    .aligned_data  (aligned_data),
    .aligned_valid (aligned_valid),
    .frame_data    (frame_data),
    .frame_valid   (frame_valid)
  );

  // absorbs hold periods, drops input once full
  adc_sample_fifo adc_sample_fifo_i (
    .clk      (clk),
    .rst      (rst),
    .wr       (frame_valid),
    .wr_data  (frame_data),
    .rd       (fifo_rd),
    .rd_data  (rd_data),
    .empty    (empty),
    .overflow (adc_overflow)
  );

  adc_data_format adc_data_format_i (
    .clk           (clk),
    .rst           (rst),
    .empty         (empty),
    .hold          (adc_hold),
    .offset_binary (offset_binary),
    .rd            (fifo_rd),
    .rd_data       (rd_data),
    .adc_data      (adc_data),
    .adc_valid     (adc_valid)
  );

endmodule

`default_nettype wire

/* tb/jesd_tpl_adc_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module jesd_tpl_adc_asserts
  import jesd_tpl_pkg::*;
(
  input wire             clk,
  input wire             rst,
  input wire sof_t       link_sof,
  input wire             adc_hold,
  input wire adc_frame_t adc_data,
  input wire             adc_valid,
  input wire             adc_overflow
);

  // running count of failed checks
  int error_count = 0;

  // set once the link has shown a frame start since reset
  logic sof_seen;

  always_ff @(posedge clk) begin
    if (rst) begin
      sof_seen <= 1'b0;
    end else if (link_sof != '0) begin
      sof_seen <= 1'b1;
    end
  end

  // top two bits of every sample copy bit 13
  function automatic logic sign_ok(input adc_frame_t d);
    logic ok;
    ok = 1'b1;
    for (int k = 0; k < samples_per_frame; k++) begin
      if (d[k*16+14 +: 2] != {2{d[k*16+13]}}) begin
        ok = 1'b0;
      end
    end
    sign_ok = ok;
  endfunction

  // **************************************************
  // control timing
  // **************************************************

  a_reset_quiet: assert property (@(posedge clk) rst |=> (!adc_valid && !adc_overflow))
    else begin
      $error("adc_valid or adc_overflow high after reset");
      error_count++;
    end

  a_no_data_before_sof: assert property (@(posedge clk) disable iff (rst)
    !sof_seen |-> !adc_valid)
    else begin
      $error("adc_valid before any frame start");
      error_count++;
    end

  // a held cycle never feeds the next output
  a_hold_stalls: assert property (@(posedge clk) disable iff (rst) adc_hold |=> !adc_valid)
    else begin
      $error("adc_valid right after a held cycle");
      error_count++;
    end

  a_overflow_sticky: assert property (@(posedge clk) disable iff (rst)
    adc_overflow |=> adc_overflow)
    else begin
      $error("adc_overflow cleared without reset");
      error_count++;
    end

  a_sign_extended: assert property (@(posedge clk) disable iff (rst)
    adc_valid |-> sign_ok(adc_data))
    else begin
      $error("output sample not sign extended");
      error_count++;
    end

endmodule

`default_nettype wire

/* tb/tb_jesd_tpl_adc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_jesd_tpl_adc
  import jesd_tpl_pkg::*;
();

  logic       clk;
  logic       rst;
  sof_t       link_sof;
  link_word_t link_data;
  logic       adc_hold;
  logic       offset_binary;
  adc_frame_t adc_data;
  logic       adc_valid;
  logic       adc_overflow;

  // stimulus generator state
  logic [15:0] lfsr_state;

  // reference model state, advanced once per clock edge
  link_word_t model_prev;
  logic       model_locked = 1'b0;
  logic [1:0] model_off = 2'd0;
  // aligned frames still on their way to the fifo
  logic       p1_valid = 1'b0;
  logic       p2_valid = 1'b0;
  adc_frame_t p1_frame;
  adc_frame_t p2_frame;
  int         occ = 0;
  logic       model_ovf = 1'b0;
  int         drops = 0;
  int         pushed = 0;
  int         popped = 0;
  int         frames_checked = 0;
  adc_frame_t exp_q[$];

  jesd_tpl_adc jesd_tpl_adc_i (
    .clk           (clk),
    .rst           (rst),
    .link_sof      (link_sof),
    .link_data     (link_data),
    .adc_hold      (adc_hold),
    .offset_binary (offset_binary),
    .adc_data      (adc_data),
    .adc_valid     (adc_valid),
    .adc_overflow  (adc_overflow)
  );

  bind jesd_tpl_adc jesd_tpl_adc_asserts jesd_tpl_adc_asserts_i (
    .clk          (clk),
    .rst          (rst),
    .link_sof     (link_sof),
    .adc_hold     (adc_hold),
    .adc_data     (adc_data),
    .adc_valid    (adc_valid),
    .adc_overflow (adc_overflow)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // **************************************************
  // random link octets
  // **************************************************

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    lfsr_next = {s[14:0], fb};
  endfunction

  // one lfsr step per bit of the word
  task automatic random_word(output link_word_t w);
    for (int i = 0; i < num_lanes * 32; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w[i] = lfsr_state[0];
    end
  endtask

  // **************************************************
  // reference model
  // **************************************************

  function automatic logic [1:0] sof_position(input sof_t s);
    case (s)
      4'b0010: sof_position = 2'd1;
      4'b0100: sof_position = 2'd2;
      4'b1000: sof_position = 2'd3;
      default: sof_position = 2'd0;
    endcase
  endfunction

  // per lane, current word above the previous one, then skip off octets
  function automatic link_word_t align_word(input link_word_t cur, input link_word_t prev,
                                            input logic [1:0] off);
    logic [63:0] pair;
    link_word_t  w;
    for (int n = 0; n < num_lanes; n++) begin
      pair = {cur[n*32 +: 32], prev[n*32 +: 32]};
      pair = pair >> (8 * off);
      w[n*32 +: 32] = pair[31:0];
    end
    align_word = w;
  endfunction

  // octets 2k and 2k+1 make sample k, big-endian, tail bits dropped
  function automatic adc_frame_t format_frame(input link_word_t a, input logic ob);
    logic [7:0]               first_oct;
    logic [7:0]               second_oct;
    logic [channel_width-1:0] s;
    adc_frame_t               f;
    for (int k = 0; k < samples_per_frame; k++) begin
      first_oct = a[(2*k)*8 +: 8];
      second_oct = a[(2*k+1)*8 +: 8];
      s = {first_oct, second_oct[7:tail_bits]};
      // offset binary flips the msb
      if (ob) begin
        s[channel_width-1] = ~s[channel_width-1];
      end
      f[k*adc_sample_width +: adc_sample_width] =
        {{(adc_sample_width - channel_width){s[channel_width-1]}}, s};
    end
    format_frame = f;
  endfunction

  // inputs seen here are the ones the DUT takes at the next rising edge
  task automatic model_edge();
    logic       rd;
    logic [1:0] off;
    if (rst) begin
      model_locked = 1'b0;
      model_off = 2'd0;
      p1_valid = 1'b0;
      p2_valid = 1'b0;
      occ = 0;
      model_ovf = 1'b0;
      drops = 0;
      pushed = 0;
      popped = 0;
      exp_q.delete();
    end else begin
      rd = (occ > 0) && !adc_hold;
      // fifo full is judged before this edge's read
      if (p2_valid) begin
        if (occ == fifo_depth) begin
          model_ovf = 1'b1;
          drops++;
        end else begin
          exp_q.push_back(p2_frame);
          pushed++;
          occ++;
        end
      end
      if (rd) begin
        occ--;
      end
      p2_valid = p1_valid;
      p2_frame = p1_frame;
      if (model_locked || (link_sof != '0)) begin
        off = model_locked ? model_off : sof_position(link_sof);
        p1_frame = format_frame(align_word(link_data, model_prev, off), offset_binary);
        p1_valid = 1'b1;
        model_locked = 1'b1;
        model_off = off;
      end else begin
        p1_valid = 1'b0;
      end
    end
    model_prev = link_data;
  endtask

  // **************************************************
  // output checks
  // **************************************************

  task automatic report_mismatch(input adc_frame_t got, input adc_frame_t want);
    int idx;
    idx = 0;
    for (int k = samples_per_frame - 1; k >= 0; k--) begin
      if (got[k*16 +: 16] != want[k*16 +: 16]) begin
        idx = k;
      end
    end
    $display("Mismatch at %0t: sample %0d is %h, expected %h", $time, idx,
             got[idx*16 +: 16], want[idx*16 +: 16]);
  endtask

  task automatic check_outputs(output logic bad);
    adc_frame_t want;
    bad = 1'b0;
    if (adc_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("adc_valid at %0t with no frame expected", $time);
        bad = 1'b1;
      end else begin
        want = exp_q.pop_front();
        popped++;
        frames_checked++;
        assert (adc_data == want) else begin
          report_mismatch(adc_data, want);
          bad = 1'b1;
        end
      end
    end
    assert (adc_overflow == model_ovf) else begin
      $display("Mismatch at %0t: adc_overflow is %b, expected %b", $time, adc_overflow,
               model_ovf);
      bad = 1'b1;
    end
    if (jesd_tpl_adc_i.jesd_tpl_adc_asserts_i.error_count != 0) begin
      $display("a concurrent assertion on the DUT failed before %0t", $time);
      bad = 1'b1;
    end
  endtask

  // outputs are settled mid cycle, compare first and then step the model
  always @(negedge clk) begin
    logic bad;
    check_outputs(bad);
    model_edge();
    if (bad) begin
      $display("Test failed");
      $fatal(1, "stopped at the first error");
    end
  end

  // **************************************************
  // stimulus
  // **************************************************

  task automatic drive_word(input sof_t sof, input logic hold);
    link_word_t w;
    @(posedge clk);
    random_word(w);
    link_data <= w;
    link_sof <= sof;
    adc_hold <= hold;
  endtask

  // offset_binary only changes while the DUT sits in reset
  task automatic reset_dut(input logic ob);
    @(posedge clk);
    rst <= 1'b1;
    adc_hold <= 1'b0;
    link_sof <= '0;
    @(posedge clk);
    offset_binary <= ob;
    @(posedge clk);
    @(posedge clk);
    rst <= 1'b0;
  endtask

  // link keeps running while the buffered frames come out
  task automatic wait_frames(input int target, output logic ok);
    int cycles;
    cycles = 0;
    while ((popped < target) && (cycles < 60)) begin
      drive_word('0, 1'b0);
      cycles++;
    end
    ok = (popped >= target);
    if (!ok) begin
      $display("no adc_valid for %0d cycles, %0d of %0d frames seen", cycles, popped, target);
    end
  endtask

  // one aligned stream from reset, with an optional hold window
  task automatic run_link(input logic [1:0] pos, input logic ob, input int hold_start,
                          input int hold_len, input int n_words, input logic expect_drop,
                          output logic ok);
    int target;
    reset_dut(ob);
    // idle words first, nothing may come out before the frame marker
    repeat (3) drive_word('0, 1'b0);
    drive_word(sof_t'(4'b0001 << pos), 1'b0);
    for (int i = 0; i < n_words; i++) begin
      drive_word('0, (i >= hold_start) && (i < hold_start + hold_len));
    end
    target = pushed;
    wait_frames(target, ok);
    if (ok && ((drops != 0) != expect_drop)) begin
      $display("offset %0d run dropped %0d frames, against what was expected", pos, drops);
      ok = 1'b0;
    end
  endtask

  initial begin
    logic ok;
    clk = 1'b0;
    rst = 1'b1;
    link_sof = '0;
    link_data = '0;
    adc_hold = 1'b0;
    offset_binary = 1'b0;
    lfsr_state = 16'd5;
    ok = 1'b1;
    // every start of frame position, plain two's complement
    for (int p = 0; p < 4; p++) begin
      if (ok) begin
        run_link(2'(p), 1'b0, 0, 0, 24, 1'b0, ok);
      end
    end
    // offset binary with a short hold, nothing lost
    if (ok) begin
      run_link(2'd1, 1'b1, 6, 4, 24, 1'b0, ok);
    end
    // holds long enough to overflow the eight frame buffer
    if (ok) begin
      run_link(2'd2, 1'b1, 4, 14, 30, 1'b1, ok);
    end
    if (ok) begin
      run_link(2'd3, 1'b0, 5, 12, 30, 1'b1, ok);
    end
    if (ok && (frames_checked < 120)) begin
      $display("only %0d frames were checked", frames_checked);
      ok = 1'b0;
    end
    if (ok) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "run aborted");
    end
  end

endmodule

`default_nettype wire
